// ==== bench/tb_mod_top.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "mod_cfg.svh"

module tb_mod_top;
  import mod_pkg::*;

  localparam int TICK      = `MOD_TICK_DIV;
  localparam int CYCLE     = 7;
  localparam int LOOP      = CYCLE + 1;
  localparam int SEL_SEG   = 0;
  localparam int SEL_STOP  = 1;
  localparam int SEL_VALID = 2;

  // the cycle budgets of all phases bound the run
  localparam int CYC_FILL  = 2 * `MOD_DEPTH + 16;
  localparam int CYC_TESTS = 80 + (3 * LOOP * TICK + 40) + (2 * LOOP * TICK + 40)
                           + (100 + 4 * TICK + 20) + (4 * LOOP * TICK + 10 * TICK + 40);
  localparam int CYC_LIMIT = 10 + CYC_FILL + CYC_TESTS + 500;

  logic                   CLK = 1'b0;
  logic                   rst_n;
  mod_cmd_t               cmd;
  logic                   cmd_valid;
  logic                   cmd_ready;
  mod_wr_t                wr;
  logic                   wr_valid;
  logic [63:0]            sys_time;
  logic [`MOD_GPIO_N-1:0] gpio;
  mod_sample_t            sample;
  logic                   sample_valid;
  logic                   sample_ready;
  logic                   stop;
  logic                   segment;

  logic [7:0]  model [2 * `MOD_DEPTH];
  mod_sample_t rx_q [$];
  mod_sample_t prev;
  mod_sample_t exp_s;
  logic        have_prev = 1'b0;
  logic        data_chk = 1'b0;
  logic        order_chk = 1'b0;
  integer      seed;
  int          err_cnt = 0;
  int          test_cnt = 0;
  int          fail_cnt = 0;
  int          cyc_cnt = 0;

  mod_top DUT (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .cmd          (cmd),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .wr           (wr),
    .wr_valid     (wr_valid),
    .sys_time     (sys_time),
    .gpio         (gpio),
    .sample       (sample),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready),
    .stop         (stop),
    .segment      (segment)
  );

  always #5 CLK = ~CLK;

  // system time advances once per clock
  initial begin
    sys_time = '0;
    forever begin
      @(posedge CLK);
      #1;
      sys_time <= sys_time + 64'd1;
    end
  end

  always @(posedge CLK) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= CYC_LIMIT) begin
      $display("ERROR: run did not finish within %0d cycles", CYC_LIMIT);
      $display("Test failures found");
      $finish;
    end
  end

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_idx(input string name, input logic [`MOD_IDX_W-1:0] got,
                           input logic [`MOD_IDX_W-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_sample(input string name, input mod_sample_t got, input mod_sample_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  // transfers are sampled at the falling edge while inputs are stable
  always @(negedge CLK) begin
    if (!order_chk) begin
      have_prev = 1'b0;
    end
    if (rst_n && sample_valid && sample_ready) begin
      rx_q.push_back(sample);
      if (data_chk) begin
        exp_s      = sample;
        exp_s.data = model[{sample.seg, sample.idx}];
        check_sample("sample", sample, exp_s);
      end
      // idx only moves back when it wraps to 0
      if (have_prev && (sample.seg == prev.seg) && (sample.idx < prev.idx)) begin
        check_idx("sample.idx", sample.idx, '0);
      end
      prev      = sample;
      have_prev = order_chk;
    end
  end

  task automatic step();
    @(posedge CLK);
    #1;
  endtask

  task automatic wait_bit(input string what, input int sel, input logic exp, input int max_cyc,
                          output int n);
    logic cur;
    n   = 0;
    cur = ~exp;
    while ((cur !== exp) && (n < max_cyc)) begin
      step();
      n++;
      case (sel)
        SEL_SEG:  cur = segment;
        SEL_STOP: cur = stop;
        default:  cur = sample_valid;
      endcase
    end
    if (cur !== exp) begin
      $display("ERROR: %s did not become %0d within %0d cycles", what, exp, max_cyc);
      err_cnt++;
    end
  endtask

  task automatic send_cmd(input mod_op_e op, input logic seg, input trans_mode_e mode,
                          input logic [63:0] value);
    int n;
    n         = 0;
    cmd.op    = op;
    cmd.seg   = seg;
    cmd.mode  = mode;
    cmd.value = value;
    cmd_valid = 1'b1;
    while (!cmd_ready && (n < 16)) begin
      step();
      n++;
    end
    if (!cmd_ready) begin
      $display("ERROR: cmd_ready stayed low for %0d cycles", n);
      err_cnt++;
    end
    step();
    cmd_valid = 1'b0;
  endtask

  task automatic fill_buffer();
    logic [15:0] addr;
    logic [31:0] rnd;
    for (int a = 0; a < 2 * `MOD_DEPTH; a++) begin
      addr        = a[15:0];
      rnd         = $random(seed);
      wr.seg      = addr[15];
      wr.addr     = addr[14:0];
      wr.data     = rnd[7:0];
      wr_valid    = 1'b1;
      model[addr] = rnd[7:0];
      step();
    end
    wr_valid = 1'b0;
    step();
    step();
    data_chk = 1'b1;
  endtask

  task automatic report_test(input string name, input int err_start);
    test_cnt++;
    if (err_cnt == err_start) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_start);
    end
  endtask

  task automatic test_immediate_swap();
    int e0;
    e0 = err_cnt;
    send_cmd(OP_SET_CYCLE, 1'b0, TRANS_SYNC_IDX, CYCLE);
    send_cmd(OP_SET_CYCLE, 1'b1, TRANS_SYNC_IDX, CYCLE);
    // rep of segment 1 is still all ones
    send_cmd(OP_SWAP, 1'b1, TRANS_SYNC_IDX, 64'd0);
    check_bit("cmd_ready", cmd_ready, 1'b0);
    check_bit("segment", segment, 1'b0);
    step();
    check_bit("cmd_ready", cmd_ready, 1'b1);
    check_bit("segment", segment, 1'b1);
    repeat (40) begin
      step();
      check_bit("stop", stop, 1'b0);
      check_bit("segment", segment, 1'b1);
    end
    report_test("command handshake and immediate swap", e0);
  endtask

  task automatic test_sync_loop();
    int   e0;
    int   n;
    logic found;
    e0    = err_cnt;
    found = 1'b0;
    send_cmd(OP_SET_REP, 1'b0, TRANS_SYNC_IDX, 64'd1);
    send_cmd(OP_SWAP, 1'b0, TRANS_SYNC_IDX, 64'd0);
    rx_q.delete();
    wait_bit("segment", SEL_SEG, 1'b0, LOOP * TICK + 8, n);
    step();
    step();
    // switch happens at the wrap, so segment 0 starts at idx 0
    foreach (rx_q[i]) begin
      if (!found && (rx_q[i].seg == 1'b0)) begin
        check_idx("sample.idx", rx_q[i].idx, '0);
        found = 1'b1;
      end
    end
    if (!found) begin
      $display("ERROR: no sample from segment 0 after the sync swap");
      err_cnt++;
    end
    wait_bit("stop", SEL_STOP, 1'b1, 2 * LOOP * TICK + 16, n);
    if (n < 2 * LOOP * TICK - 2 * TICK) begin
      $display("ERROR: stop rose %0d cycles after the swap, before two loops", n);
      err_cnt++;
    end
    repeat (4) begin
      step();
      check_bit("stop", stop, 1'b1);
      check_bit("segment", segment, 1'b0);
    end
    report_test("sync index finite loop", e0);
  endtask

  task automatic test_time_swap();
    int          e0;
    int          n;
    int          k;
    logic [63:0] t_val;
    e0 = err_cnt;
    k  = 0;
    send_cmd(OP_SET_REP, 1'b1, TRANS_SYNC_IDX, 64'd0);
    t_val = sys_time + 64'd20;
    send_cmd(OP_SWAP, 1'b1, TRANS_SYS_TIME, t_val);
    wait_bit("segment", SEL_SEG, 1'b1, 20 + 10, n);
    if (sys_time <= t_val) begin
      $display("ERROR: segment switched at sys_time 0x%h, not past 0x%h", sys_time, t_val);
      err_cnt++;
    end
    rx_q.delete();
    wait_bit("stop", SEL_STOP, 1'b1, LOOP * TICK + 4, n);
    if (n < CYCLE * TICK) begin
      $display("ERROR: stop rose %0d cycles after the swap, before one loop", n);
      err_cnt++;
    end
    step();
    step();
    foreach (rx_q[i]) begin
      if ((rx_q[i].seg == 1'b1) && (k < LOOP)) begin
        check_idx("sample.idx", rx_q[i].idx, k[`MOD_IDX_W-1:0]);
        k++;
      end
    end
    if (k < LOOP) begin
      $display("ERROR: only %0d samples from segment 1 before stop", k);
      err_cnt++;
    end
    report_test("system time transition", e0);
  endtask

  task automatic test_gpio_swap();
    int e0;
    int n;
    e0 = err_cnt;
    send_cmd(OP_SWAP, 1'b0, TRANS_GPIO, 64'd2);
    repeat (100) begin
      step();
      check_bit("segment", segment, 1'b1);
      check_bit("stop", stop, 1'b0);
    end
    gpio[2] = 1'b1;
    wait_bit("segment", SEL_SEG, 1'b0, TICK + 4, n);
    gpio = '0;
    report_test("gpio transition", e0);
  endtask

  task automatic test_sample_stream();
    int          e0;
    int          n;
    int          nxt;
    mod_sample_t stalled;
    mod_sample_t exp_h;
    e0 = err_cnt;
    rx_q.delete();
    order_chk = 1'b1;
    repeat (4 * LOOP * TICK) begin
      step();
    end
    order_chk = 1'b0;
    if (rx_q.size() < 4 * LOOP - 2) begin
      $display("ERROR: only %0d samples received with sample_ready high", rx_q.size());
      err_cnt++;
    end
    sample_ready = 1'b0;
    wait_bit("sample_valid", SEL_VALID, 1'b1, 2 * TICK, n);
    stalled = sample;
    repeat (5 * TICK) begin
      step();
      check_bit("sample_valid", sample_valid, 1'b1);
    end
    // five index steps replace the stalled sample with the newest one
    nxt          = (int'(stalled.idx) + 5) % LOOP;
    exp_h.seg    = 1'b0;
    exp_h.idx    = nxt[`MOD_IDX_W-1:0];
    exp_h.data   = model[{exp_h.seg, exp_h.idx}];
    sample_ready = 1'b1;
    rx_q.delete();
    step();
    if (rx_q.size() == 0) begin
      $display("ERROR: no sample transferred after sample_ready was released");
      err_cnt++;
    end else begin
      check_sample("sample", rx_q[0], exp_h);
    end
    report_test("sample data and back-pressure", e0);
  endtask

  initial begin
    rst_n        = 1'b0;
    cmd          = '0;
    cmd_valid    = 1'b0;
    wr           = '0;
    wr_valid     = 1'b0;
    gpio         = '0;
    sample_ready = 1'b1;
    seed         = 32'hb11a_1fdb;
    repeat (10) begin
      @(posedge CLK);
    end
    #1;
    rst_n = 1'b1;
    fill_buffer();
    test_immediate_swap();
    test_sync_loop();
    test_time_swap();
    test_gpio_swap();
    test_sample_stream();
    $display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/mod_buffer.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "mod_cfg.svh"

module mod_buffer (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  mod_pkg::mod_wr_t      wr,
  input  logic                  wr_valid,
  input  logic                  segment,
  input  logic [`MOD_IDX_W-1:0] idx,
  output mod_pkg::mod_sample_t  sample,
  output logic                  sample_valid,
  input  logic                  sample_ready
);

  localparam int ADDR_W = $clog2(`MOD_NUM_SEG * `MOD_DEPTH);

  logic [7:0]            mem [`MOD_NUM_SEG * `MOD_DEPTH];
  logic [ADDR_W-1:0]     wr_addr;
  logic [ADDR_W-1:0]     rd_addr;
  logic                  seg_q;
  logic [`MOD_IDX_W-1:0] idx_q;
  logic                  rd_en;

  // segment selects the upper half of the ram
  assign wr_addr = {wr.seg, wr.addr};
  assign rd_addr = {segment, idx};
  assign rd_en   = (segment != seg_q) || (idx != idx_q);

  always_ff @(posedge CLK) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr.data;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      seg_q        <= 1'b0;
      idx_q        <= '0;
      sample_valid <= 1'b0;
    end else begin
      seg_q <= segment;
      idx_q <= idx;
      // a new read overrides an unaccepted sample
      if (rd_en) begin
        sample_valid <= 1'b1;
      end else if (sample_ready) begin
        sample_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (rd_en) begin
      sample.seg  <= segment;
      sample.idx  <= idx;
      sample.data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mod_cfg.svh ====
`ifndef MOD_CFG_SVH
`define MOD_CFG_SVH

// two segments, the swapchain toggles between them
`define MOD_NUM_SEG 2

// sample index width and samples per segment
`define MOD_IDX_W 15
`define MOD_DEPTH 32768

// clocks per index step
`define MOD_TICK_DIV 4

// selectable gpio inputs for the gpio transition
`define MOD_GPIO_N 4

`endif

// ==== rtl/mod_idx_timer.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "mod_cfg.svh"

module mod_idx_timer (
  input  logic                                 CLK,
  input  logic                                 rst_n,
  input  mod_pkg::seg_cfg_t [`MOD_NUM_SEG-1:0] cfg,
  output mod_pkg::idx_vec_t                    sync_idx
);

  localparam int PRE_W = (`MOD_TICK_DIV > 1) ? $clog2(`MOD_TICK_DIV) : 1;

  logic [PRE_W-1:0] pre_cnt;
  logic             tick;

  assign tick = (pre_cnt == PRE_W'(`MOD_TICK_DIV - 1));

  // prescaler, one tick every MOD_TICK_DIV clocks
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      pre_cnt <= '0;
    end else if (tick) begin
      pre_cnt <= '0;
    end else begin
      pre_cnt <= pre_cnt + 1'b1;
    end
  end

  // one free-running index per segment, independent of the active one
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      sync_idx <= '0;
    end else if (tick) begin
      for (int s = 0; s < `MOD_NUM_SEG; s++) begin
        // >= also catches a cycle shortened below the running index
        if (sync_idx[s] >= cfg[s].cycle) begin
          sync_idx[s] <= '0;
        end else begin
          sync_idx[s] <= sync_idx[s] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mod_pkg.sv ====
`default_nettype none

`include "mod_cfg.svh"

package mod_pkg;

  typedef enum logic [1:0] {
    OP_SET_CYCLE = 2'd0,
    OP_SET_REP   = 2'd1,
    OP_SWAP      = 2'd2
  } mod_op_e;

  // encodings follow the host protocol
  typedef enum logic [7:0] {
    TRANS_SYNC_IDX = 8'h00,
    TRANS_SYS_TIME = 8'h01,
    TRANS_GPIO     = 8'h02,
    TRANS_EXT      = 8'hf0
  } trans_mode_e;

  typedef enum logic [1:0] {
    ST_WAIT_START = 2'd0,
    ST_FINITE     = 2'd1,
    ST_INFINITE   = 2'd2
  } swap_state_e;

  // value carries cycle, repeat count or transition value
  typedef struct packed {
    mod_op_e     op;
    logic        seg;
    trans_mode_e mode;
    logic [63:0] value;
  } mod_cmd_t;

  typedef struct packed {
    logic [`MOD_IDX_W-1:0] cycle;
    logic [31:0]           rep;
  } seg_cfg_t;

  typedef struct packed {
    logic        seg;
    trans_mode_e mode;
    logic [63:0] value;
    logic [31:0] rep;
  } swap_req_t;

  typedef logic [`MOD_NUM_SEG-1:0][`MOD_IDX_W-1:0] idx_vec_t;

  typedef struct packed {
    logic                  seg;
    logic [`MOD_IDX_W-1:0] addr;
    logic [7:0]            data;
  } mod_wr_t;

  typedef struct packed {
    logic                  seg;
    logic [`MOD_IDX_W-1:0] idx;
    logic [7:0]            data;
  } mod_sample_t;

endpackage

`default_nettype wire

// ==== rtl/mod_settings.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "mod_cfg.svh"

module mod_settings (
  input  logic                                 CLK,
  input  logic                                 rst_n,
  input  mod_pkg::mod_cmd_t                    cmd,
  input  logic                                 cmd_valid,
  output logic                                 cmd_ready,
  output mod_pkg::seg_cfg_t [`MOD_NUM_SEG-1:0] cfg,
  output mod_pkg::swap_req_t                   req,
  output logic                                 update
);
  import mod_pkg::*;

  logic cmd_fire;
  logic swap_fire;

  assign cmd_fire  = cmd_valid && cmd_ready;
  assign swap_fire = cmd_fire && (cmd.op == OP_SWAP);

  // ready drops for the single cycle in which update is presented
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      cmd_ready <= 1'b1;
      update    <= 1'b0;
    end else begin
      cmd_ready <= !swap_fire;
      update    <= swap_fire;
    end
  end

  // per-segment cycle and repeat registers
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      for (int s = 0; s < `MOD_NUM_SEG; s++) begin
        cfg[s].cycle <= '1;
        cfg[s].rep   <= '1;
      end
    end else if (cmd_fire) begin
      case (cmd.op)
        OP_SET_CYCLE: begin
          cfg[cmd.seg].cycle <= cmd.value[`MOD_IDX_W-1:0];
        end
        OP_SET_REP: begin
          cfg[cmd.seg].rep <= cmd.value[31:0];
        end
        default: begin
        end
      endcase
    end
  end

  // swap request, rep is taken from the target segment at acceptance
  always_ff @(posedge CLK) begin
    if (swap_fire) begin
      req.seg   <= cmd.seg;
      req.mode  <= cmd.mode;
      req.value <= cmd.value;
      req.rep   <= cfg[cmd.seg].rep;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mod_swapchain.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "mod_cfg.svh"

module mod_swapchain (
  input  logic                                 CLK,
  input  logic                                 rst_n,
  input  logic                                 update,
  input  mod_pkg::swap_req_t                   req,
  input  mod_pkg::seg_cfg_t [`MOD_NUM_SEG-1:0] cfg,
  input  mod_pkg::idx_vec_t                    sync_idx,
  input  logic [63:0]                          sys_time,
  input  logic [`MOD_GPIO_N-1:0]               gpio,
  output logic                                 segment,
  output logic [`MOD_IDX_W-1:0]                idx,
  output logic                                 stop
);
  import mod_pkg::*;

  localparam int GPIO_SEL_W = (`MOD_GPIO_N > 1) ? $clog2(`MOD_GPIO_N) : 1;

  swap_state_e             state;
  logic                    req_seg;
  logic [31:0]             rep;
  logic [31:0]             loop_cnt;
  logic                    use_tic;
  logic                    ext_mode;
  logic [`MOD_IDX_W-1:0]   tic_idx;
  idx_vec_t                idx_old;
  logic [`MOD_NUM_SEG-1:0] idx_changed;
  logic [`MOD_NUM_SEG-1:0] idx_wrapped;
  logic signed [64:0]      time_diff;
  logic                    gpio_sel;
  logic                    at_cycle;
  logic                    start_hit;
  logic                    loop_tick;

  always_comb begin
    for (int s = 0; s < `MOD_NUM_SEG; s++) begin
      idx_changed[s] = (idx_old[s] != sync_idx[s]);
      idx_wrapped[s] = idx_changed[s] && (sync_idx[s] == '0);
    end
  end

  assign gpio_sel = gpio[req.value[GPIO_SEL_W-1:0]];
  assign at_cycle = (tic_idx >= cfg[segment].cycle);

  // sync mode shows the segment's own index, otherwise the local tic count
  assign idx = use_tic ? tic_idx : idx_old[segment];

  // goes negative once sys_time has passed the transition value
  always_ff @(posedge CLK) begin
    time_diff <= $signed({1'b0, req.value}) - $signed({1'b0, sys_time});
  end

  always_comb begin
    case (req.mode)
      TRANS_SYNC_IDX: start_hit = idx_wrapped[req_seg];
      TRANS_SYS_TIME: start_hit = time_diff[64];
      TRANS_GPIO:     start_hit = idx_changed[req_seg] && gpio_sel;
      default:        start_hit = 1'b0;
    endcase
  end

  // one loop ends at a sync wrap, or when the tic index wraps
  assign loop_tick = use_tic ? (idx_changed[segment] && at_cycle) : idx_wrapped[segment];

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      idx_old <= '0;
    end else begin
      idx_old <= sync_idx;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state    <= ST_INFINITE;
      segment  <= 1'b0;
      req_seg  <= 1'b0;
      rep      <= '1;
      loop_cnt <= '0;
      stop     <= 1'b0;
      use_tic  <= 1'b0;
      ext_mode <= 1'b0;
      tic_idx  <= '0;
    end else if (update) begin
      stop <= 1'b0;
      if ((req.seg == segment) || (req.rep == '1)) begin
        // same segment only reloads the mode
        segment  <= req.seg;
        use_tic  <= 1'b0;
        ext_mode <= (req.mode == TRANS_EXT);
        state    <= ST_INFINITE;
      end else begin
        req_seg <= req.seg;
        rep     <= req.rep;
        state   <= ST_WAIT_START;
      end
    end else begin
      case (state)
        ST_WAIT_START: begin
          if (start_hit) begin
            segment  <= req_seg;
            loop_cnt <= '0;
            tic_idx  <= '0;
            use_tic  <= (req.mode != TRANS_SYNC_IDX);
            ext_mode <= 1'b0;
            state    <= ST_FINITE;
          end
        end
        ST_FINITE: begin
          if (use_tic && idx_changed[segment]) begin
            tic_idx <= at_cycle ? '0 : tic_idx + 1'b1;
          end
          if (loop_tick) begin
            // stop holds until the next update
            if (loop_cnt == rep) begin
              stop <= 1'b1;
            end else begin
              loop_cnt <= loop_cnt + 1'b1;
            end
          end
        end
        ST_INFINITE: begin
          // external mode alternates segments at each wrap
          if (ext_mode && idx_wrapped[segment]) begin
            segment <= ~segment;
          end
        end
        default: begin
          state <= ST_INFINITE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mod_top.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "mod_cfg.svh"

module mod_top (
  input  logic                   CLK,
  input  logic                   rst_n,
  input  mod_pkg::mod_cmd_t      cmd,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  input  mod_pkg::mod_wr_t       wr,
  input  logic                   wr_valid,
  input  logic [63:0]            sys_time,
  input  logic [`MOD_GPIO_N-1:0] gpio,
  output mod_pkg::mod_sample_t   sample,
  output logic                   sample_valid,
  input  logic                   sample_ready,
  output logic                   stop,
  output logic                   segment
);
  import mod_pkg::*;

  seg_cfg_t [`MOD_NUM_SEG-1:0] cfg;
  swap_req_t                   req;
  logic                        update;
  idx_vec_t                    sync_idx;
  logic [`MOD_IDX_W-1:0]       idx;

  mod_settings u_settings (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cfg       (cfg),
    .req       (req),
    .update    (update)
  );

  mod_idx_timer u_idx_timer (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .cfg      (cfg),
    .sync_idx (sync_idx)
  );

  mod_swapchain u_swapchain (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .update   (update),
    .req      (req),
    .cfg      (cfg),
    .sync_idx (sync_idx),
    .sys_time (sys_time),
    .gpio     (gpio),
    .segment  (segment),
    .idx      (idx),
    .stop     (stop)
  );

  mod_buffer u_buffer (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .wr           (wr),
    .wr_valid     (wr_valid),
    .segment      (segment),
    .idx          (idx),
    .sample       (sample),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
  --top-module tb_mod_top -f sources.f

out=$(./obj_dir/Vtb_mod_top)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF 'All tests passed!'; then
  exit 0
fi
exit 1

// ==== sources.f ====
+incdir+rtl
rtl/mod_pkg.sv
rtl/mod_settings.sv
rtl/mod_idx_timer.sv
rtl/mod_swapchain.sv
rtl/mod_buffer.sv
rtl/mod_top.sv
bench/tb_mod_top.sv
